/* bench/decodeMulDivVectors.svh */
`ifndef DECODE_MUL_DIV_VECTORS_SVH
`define DECODE_MUL_DIV_VECTORS_SVH

// One row: instruction, operands, expected bundle and expected M result
typedef struct packed {
	logic [`XLEN-1:0] instr;
	logic [`XLEN-1:0] a;
	logic [`XLEN-1:0] b;
	ctrlBundleS       expCtrl;
	logic             isMd;
	logic [`XLEN-1:0] expVal;
} vecS;

vecS   vecs [$];
string vecNames [$];
int    phaseEnd [$];   // One past the last row of each phase
string phaseNames [$];

// Register fields are don't care for the decoder
function automatic logic [`XLEN-1:0] encode(logic [6:0] f7, logic [2:0] f3,
		logic [6:0] opc);
	return {f7, 5'd2, 5'd1, f3, 5'd3, opc};
endfunction

function automatic ctrlBundleS mkCtrl(logic rw, immSrcE imm, logic [1:0] srcA, logic srcB,
		logic mw, resultSrcE res, logic [1:0] brJmp, logic [1:0] aluOp, logic jal,
		writeTypeE wt);
	ctrlBundleS c;
	c            = '0;
	c.regWrite   = rw;
	c.immSrc     = imm;
	c.aluSrcA    = srcA;
	c.aluSrcB    = srcB;
	c.memWrite   = mw;
	c.resultSrc  = res;
	c.branch     = brJmp[1];
	c.jump       = brJmp[0];
	c.aluOp      = aluOp;
	c.pcJalSrc   = jal;
	c.writeType  = wt;
	c.mulDivFunc = MD_MUL;
	return c;
endfunction

// RISC-V M extension reference
function automatic logic [`XLEN-1:0] mdModel(mulDivFuncE f, logic [`XLEN-1:0] a,
		logic [`XLEN-1:0] b);
	logic [2*`XLEN-1:0] sa;
	logic [2*`XLEN-1:0] ua;
	logic [2*`XLEN-1:0] sb;
	logic [2*`XLEN-1:0] ub;
	logic [2*`XLEN-1:0] prod;
	logic               ovf;
	sa  = {{`XLEN{a[`XLEN-1]}}, a};
	ua  = {{`XLEN{1'b0}}, a};
	sb  = {{`XLEN{b[`XLEN-1]}}, b};
	ub  = {{`XLEN{1'b0}}, b};
	ovf = (a == {1'b1, {(`XLEN-1){1'b0}}}) && (b == '1);
	if (f inside {MD_MUL, MD_MULH, MD_MULHSU, MD_MULHU}) begin
		case (f)
			MD_MUL, MD_MULHU: prod = ua * ub;
			MD_MULH:          prod = sa * sb;
			default:          prod = sa * ub;
		endcase
		return (f == MD_MUL) ? prod[`XLEN-1:0] : prod[2*`XLEN-1:`XLEN];
	end
	if (b == '0) return (f inside {MD_DIV, MD_DIVU}) ? '1 : a; // Divide by zero
	if (ovf && f inside {MD_DIV, MD_REM}) return (f == MD_DIV) ? a : '0;
	case (f)
		MD_DIV:  return `XLEN'($signed(a) / $signed(b));
		MD_DIVU: return a / b;
		MD_REM:  return `XLEN'($signed(a) % $signed(b));
		default: return a % b;
	endcase
endfunction

// Tag is the row index, truncated to the tag width
task automatic pushVec(string name, vecS v);
	v.expCtrl.tag = `TAG_BITS'(vecs.size());
	vecs.push_back(v);
	vecNames.push_back(name);
endtask

task automatic addVec(string name, logic [6:0] f7, logic [2:0] f3, logic [6:0] opc,
		ctrlBundleS exp);
	vecS v;
	v         = '0;
	v.instr   = encode(f7, f3, opc);
	v.expCtrl = exp;
	pushVec(name, v);
endtask

task automatic addMd(string name, mulDivFuncE f, logic [`XLEN-1:0] a, logic [`XLEN-1:0] b);
	vecS v;
	v       = '0;
	v.instr = encode(7'b0000001, f, OP_R);
	v.a     = a;
	v.b     = b;
	v.expCtrl = mkCtrl(1'b1, IMM_I, 2'b01, 1'b0, 1'b0, RES_ALU, 2'b00, 2'b10, 1'b0, WT_WORD);
	v.expCtrl.isMulDiv   = 1'b1;
	v.expCtrl.mulDivFunc = f;
	v.isMd   = 1'b1;
	v.expVal = mdModel(f, a, b);
	pushVec(name, v);
endtask

task automatic endPhase(string name);
	phaseEnd.push_back(vecs.size());
	phaseNames.push_back(name);
endtask

task automatic buildTable();
	logic [`XLEN-1:0] mulA [4];
	logic [`XLEN-1:0] mulB [4];
	logic [`XLEN-1:0] divA [4];
	logic [`XLEN-1:0] divB [4];
	ctrlBundleS       immCtrl;
	ctrlBundleS       bad;
	mulDivFuncE       fn;
	logic [`XLEN-1:0] opA;
	logic [`XLEN-1:0] opB;
	mulA = '{32'h8000_0000, 32'hFFFF_FFFF, 32'h7FFF_FFFF, 32'h1234_5678};
	mulB = '{32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000, 32'h9ABC_DEF0};
	divA = '{32'h8000_0000, 32'h0000_0007, 32'hFFFF_FFF9, 32'h7FFF_FFFF}; // -7 in slot 2
	divB = '{32'hFFFF_FFFF, 32'h0000_0000, 32'h0000_0002, 32'hFFFF_FFFD};
	immCtrl = mkCtrl(1'b1, IMM_I, 2'b01, 1'b1, 1'b0, RES_ALU, 2'b00, 2'b01, 1'b0, WT_WORD);

	addVec("add", 7'h00, 3'd0, OP_R,
		mkCtrl(1'b1, IMM_I, 2'b01, 1'b0, 1'b0, RES_ALU, 2'b00, 2'b10, 1'b0, WT_WORD));
	addVec("addi", 7'h00, 3'd0, OP_I, immCtrl);
	addVec("sb", 7'h00, 3'd0, OP_S,
		mkCtrl(1'b0, IMM_S, 2'b01, 1'b1, 1'b1, RES_ALU, 2'b00, 2'b00, 1'b0, WT_BYTE));
	addVec("sh", 7'h00, 3'd1, OP_S,
		mkCtrl(1'b0, IMM_S, 2'b01, 1'b1, 1'b1, RES_ALU, 2'b00, 2'b00, 1'b0, WT_HALF));
	addVec("sw", 7'h00, 3'd2, OP_S,
		mkCtrl(1'b0, IMM_S, 2'b01, 1'b1, 1'b1, RES_ALU, 2'b00, 2'b00, 1'b0, WT_WORD));
	addVec("store funct3 3", 7'h00, 3'd3, OP_S,
		mkCtrl(1'b0, IMM_S, 2'b01, 1'b1, 1'b1, RES_ALU, 2'b00, 2'b00, 1'b0, WT_OTHER));
	addVec("lw", 7'h00, 3'd2, OP_L,
		mkCtrl(1'b1, IMM_I, 2'b01, 1'b1, 1'b0, RES_MEM, 2'b00, 2'b00, 1'b0, WT_WORD));
	addVec("beq", 7'h00, 3'd0, OP_B,
		mkCtrl(1'b0, IMM_BJ, 2'b01, 1'b0, 1'b0, RES_ALU, 2'b10, 2'b11, 1'b0, WT_WORD));
	addVec("jal", 7'h00, 3'd0, OP_JAL,
		mkCtrl(1'b1, IMM_BJ, 2'b01, 1'b0, 1'b0, RES_PC4, 2'b01, 2'b01, 1'b0, WT_WORD));
	addVec("jalr", 7'h00, 3'd0, OP_JALR,
		mkCtrl(1'b1, IMM_I, 2'b01, 1'b1, 1'b0, RES_PC4, 2'b01, 2'b01, 1'b1, WT_WORD));
	addVec("lui", 7'h00, 3'd0, OP_LUI,
		mkCtrl(1'b1, IMM_U, 2'b00, 1'b1, 1'b0, RES_ALU, 2'b00, 2'b01, 1'b0, WT_WORD));
	addVec("auipc", 7'h00, 3'd0, OP_AUIPC,
		mkCtrl(1'b1, IMM_U, 2'b10, 1'b1, 1'b0, RES_ALU, 2'b00, 2'b01, 1'b0, WT_WORD));
	endPhase("opcodes");

	bad = mkCtrl(1'b0, IMM_I, 2'b00, 1'b0, 1'b0, RES_ALU, 2'b00, 2'b10, 1'b0, WT_WORD);
	bad.illegal = 1'b1;
	addVec("opcode 7f", 7'h00, 3'd0, 7'h7f, bad);
	addVec("fence", 7'h00, 3'd0, 7'h0f, bad);
	endPhase("illegal");

	for (int f = 0; f < 4; f++) begin
		for (int k = 0; k < 4; k++) begin
			fn = mulDivFuncE'(3'(f));
			addMd($sformatf("%s %h %h", fn.name(), mulA[k], mulB[k]), fn, mulA[k], mulB[k]);
		end
	end
	endPhase("multiply");

	for (int f = 4; f < 8; f++) begin
		for (int k = 0; k < 4; k++) begin
			fn = mulDivFuncE'(3'(f));
			addMd($sformatf("%s %h %h", fn.name(), divA[k], divB[k]), fn, divA[k], divB[k]);
		end
	end
	endPhase("divide");

	// More M ops than lanes, with plain ALU ops mixed in
	for (int k = 0; k < 14; k++) begin
		if (k % 3 == 2) begin
			addVec($sformatf("burst addi %0d", k), 7'h00, 3'd0, OP_I, immCtrl);
		end else begin
			fn  = mulDivFuncE'(3'($urandom_range(7)));
			opA = $urandom;
			opB = (k == 4) ? '0 : $urandom;
			addMd($sformatf("burst %s %0d", fn.name(), k), fn, opA, opB);
		end
	end
	endPhase("burst");
endtask

`endif

/* bench/decodeMulDivTb.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module decodeMulDivTb import rvIsaPkg::*, rvStreamPkg::*;;
	localparam int STALL_LIMIT = 400; // Cycles without progress

	logic       clk;
	logic       arstN;
	logic       issueValid;
	logic       issueReady;
	issueBeatS  issueBeat;
	logic       ctrlValid;
	logic       ctrlReady;
	ctrlBundleS ctrlOut;
	logic       resValid;
	logic       resReady;
	mdResultS   resOut;

	int errorCount;
	int testsRun;
	int testsFailed;
	bit timedOut;
	bit stallOn;    // Random ready stalls on both outputs

	`include "decodeMulDivVectors.svh"

	decodeMulDivUnit u_dut (.*);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	task automatic checkCtrl(string name, ctrlBundleS exp, ctrlBundleS got);
		if (got !== exp) begin
			$display("Mismatch %s: expected ctrl %h, actual %h", name, exp, got);
			errorCount++;
		end
	endtask

	task automatic checkResult(string name, mdResultS exp, mdResultS got);
		if (got !== exp) begin
			$display("Mismatch %s: expected result %h, actual %h", name, exp, got);
			errorCount++;
		end
	endtask

	task automatic reportTest(string name, int errBefore);
		testsRun++;
		if (errorCount == errBefore) begin
			$display("PASS %s", name);
		end else begin
			testsFailed++;
			$display("FAIL %s with %0d errors", name, errorCount - errBefore);
		end
	endtask

	// Ready is sampled at the falling edge, transfer happens on the next rising edge
	task automatic issueRows(int first, int last);
		int waitCnt;
		@(posedge clk);
		for (int i = first; i < last && !timedOut; i++) begin
			issueValid <= 1'b1;
			issueBeat  <= '{vecs[i].instr, vecs[i].a, vecs[i].b, vecs[i].expCtrl.tag};
			waitCnt = 0;
			do begin
				@(negedge clk);
				waitCnt++;
			end while (!issueReady && waitCnt < STALL_LIMIT);
			if (!issueReady) begin
				$display("Timeout: issue of %s was never accepted", vecNames[i]);
				errorCount++;
				timedOut = 1'b1;
			end
			@(posedge clk);
		end
		issueValid <= 1'b0;
	endtask

	task automatic drainRows(int first, int last);
		int       ctrlIdx;
		int       idle;
		int       hit;
		int       pend [$]; // Rows still owed a result
		mdResultS expRes;
		ctrlIdx = first;
		idle    = 0;
		for (int i = first; i < last; i++) begin
			if (vecs[i].isMd) pend.push_back(i);
		end
		while ((ctrlIdx < last || pend.size() > 0) && idle < STALL_LIMIT) begin
			@(posedge clk);
			ctrlReady <= stallOn ? ($urandom_range(3) != 0) : 1'b1;
			resReady  <= stallOn ? ($urandom_range(2) != 0) : 1'b1;
			@(negedge clk);
			idle++;
			if (ctrlValid && ctrlReady) begin
				idle = 0;
				if (ctrlIdx < last) begin
					checkCtrl(vecNames[ctrlIdx], vecs[ctrlIdx].expCtrl, ctrlOut);
				end else begin
					$display("Unexpected extra bundle with tag %0d", ctrlOut.tag);
					errorCount++;
				end
				ctrlIdx++;
			end
			if (resValid && resReady) begin
				idle = 0;
				hit  = -1;
				foreach (pend[j]) begin
					if (hit < 0 && vecs[pend[j]].expCtrl.tag == resOut.tag) hit = j;
				end
				if (hit < 0) begin
					$display("Unexpected or duplicate result with tag %0d", resOut.tag);
					errorCount++;
				end else begin
					expRes = '{vecs[pend[hit]].expCtrl.tag, vecs[pend[hit]].expVal};
					checkResult(vecNames[pend[hit]], expRes, resOut);
					pend.delete(hit);
				end
			end
		end
		if (ctrlIdx < last || pend.size() > 0) begin
			$display("Timeout: %0d bundles never came out", (ctrlIdx < last) ? last - ctrlIdx : 0);
			foreach (pend[j]) begin
				$display("Missing result for tag %0d of %s", vecs[pend[j]].expCtrl.tag,
					vecNames[pend[j]]);
			end
			errorCount++;
			timedOut = 1'b1;
		end
		@(posedge clk);
		ctrlReady <= 1'b0;
		resReady  <= 1'b0;
	endtask

	task automatic runPhase(string name, int first, int last);
		int errBefore;
		errBefore = errorCount;
		fork
			issueRows(first, last);
			drainRows(first, last);
		join
		reportTest(name, errBefore);
	endtask

	// Called right after the reset release edge
	task automatic checkResetState();
		int errBefore;
		errBefore = errorCount;
		@(negedge clk);
		if (issueReady !== 1'b0 || ctrlValid !== 1'b0 || resValid !== 1'b0) begin
			$display("Outputs not idle after reset: issueReady %b ctrlValid %b resValid %b",
				issueReady, ctrlValid, resValid);
			errorCount++;
		end
		reportTest("reset", errBefore);
	endtask

	initial begin
		int first;
		void'($urandom(32'h1dc4));
		arstN       = 1'b0;
		issueValid  = 1'b0;
		issueBeat   = '0;
		ctrlReady   = 1'b0;
		resReady    = 1'b0;
		errorCount  = 0;
		testsRun    = 0;
		testsFailed = 0;
		timedOut    = 1'b0;
		stallOn     = 1'b0;
		buildTable();

		repeat (4) @(posedge clk);
		arstN     <= 1'b1;
		ctrlReady <= 1'b1; // Downstream ready, so only reset can hold issueReady low
		checkResetState();

		first = 0;
		foreach (phaseEnd[p]) begin
			stallOn = (phaseNames[p] == "burst");
			if (!timedOut) runPhase(phaseNames[p], first, phaseEnd[p]);
			first = phaseEnd[p];
		end

		$display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errorCount);
		if (errorCount == 0 && testsFailed == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

/* logic/decodeMulDivUnit.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module decodeMulDivUnit import rvIsaPkg::*, rvStreamPkg::*; (
	input  logic       clk,
	input  logic       arstN,
	input  logic       issueValid,
	output logic       issueReady,
	input  issueBeatS  issueBeat,
	output logic       ctrlValid,
	input  logic       ctrlReady,
	output ctrlBundleS ctrlOut,
	output logic       resValid,
	input  logic       resReady,
	output mdResultS   resOut
);
	logic                 ctrlInValid;
	logic                 ctrlInReady;
	ctrlBundleS           ctrlIn;
	logic [`MD_LANES-1:0] laneStart;
	mdOpS                 laneOp;    // Shared by all lanes, start picks one
	logic [`MD_LANES-1:0] laneBusy;
	logic [`MD_LANES-1:0] laneResultValid;
	logic [`MD_LANES-1:0] laneResultReady;
	mdResultS             laneResult [`MD_LANES];
	logic                 collValid;
	logic                 collReady;
	mdResultS             collResult;

	issueDispatch u_issueDispatch (
		.clk, .arstN, .issueValid, .issueBeat,
		.ctrlReady(ctrlInReady),
		.laneBusy,
		.issueReady,
		.ctrlValid(ctrlInValid),
		.ctrlIn, .laneStart, .laneOp
	);

	streamFifo #(.T(ctrlBundleS)) u_ctrlFifo (
		.clk, .arstN,
		.inValid(ctrlInValid), .inData(ctrlIn), .outReady(ctrlReady),
		.inReady(ctrlInReady), .outValid(ctrlValid), .outData(ctrlOut)
	);

	for (genvar i = 0; i < `MD_LANES; i++) begin : g_lane
		mulDivLane u_mulDivLane (
			.clk, .arstN,
			.start(laneStart[i]), .op(laneOp), .resultReady(laneResultReady[i]),
			.busy(laneBusy[i]), .resultValid(laneResultValid[i]), .result(laneResult[i])
		);
	end

	resultCollector u_resultCollector (
		.clk, .arstN,
		.laneValid(laneResultValid), .laneResult, .outReady(collReady),
		.laneReady(laneResultReady), .outValid(collValid), .outResult(collResult)
	);

	streamFifo #(.T(mdResultS)) u_resultFifo (
		.clk, .arstN,
		.inValid(collValid), .inData(collResult), .outReady(resReady),
		.inReady(collReady), .outValid(resValid), .outData(resOut)
	);

endmodule

/* logic/issueDispatch.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module issueDispatch import rvIsaPkg::*, rvStreamPkg::*; (
	input  logic                 clk,
	input  logic                 arstN,
	input  logic                 issueValid,
	input  issueBeatS            issueBeat,
	input  logic                 ctrlReady,
	input  logic [`MD_LANES-1:0] laneBusy,
	output logic                 issueReady,
	output logic                 ctrlValid,
	output ctrlBundleS           ctrlIn,
	output logic [`MD_LANES-1:0] laneStart,
	output mdOpS                 laneOp
);
	localparam int IDXW = (`MD_LANES > 1) ? $clog2(`MD_LANES) : 1;

	ctrlBundleS      decoded;
	logic            running; // Low until the first edge after reset
	logic            canIssue;
	logic            accept;
	logic            anyIdle;
	logic [IDXW-1:0] laneSel;
	logic [IDXW-1:0] rrPtr;   // Where the idle search starts

	mainDecoder u_mainDecoder (
		.instr(issueBeat.instr),
		.ctrl (decoded)
	);

	always_comb begin
		ctrlIn     = decoded;
		ctrlIn.tag = issueBeat.tag;
	end

	// First idle lane at or after the pointer
	always_comb begin
		int idx;
		anyIdle = 1'b0;
		laneSel = rrPtr;
		for (int k = 0; k < `MD_LANES; k++) begin
			idx = (int'(rrPtr) + k) % `MD_LANES;
			if (!anyIdle && !laneBusy[idx]) begin
				anyIdle = 1'b1;
				laneSel = IDXW'(idx);
			end
		end
	end

	assign canIssue   = running && (!decoded.isMulDiv || anyIdle);
	assign ctrlValid  = issueValid && canIssue;
	assign issueReady = canIssue && ctrlReady;
	assign accept     = issueValid && issueReady;

	always_comb begin
		laneStart = '0;
		if (accept && decoded.isMulDiv) begin
			laneStart[laneSel] = 1'b1;
		end
	end

	assign laneOp.func = decoded.mulDivFunc;
	assign laneOp.a    = issueBeat.rs1Val;
	assign laneOp.b    = issueBeat.rs2Val;
	assign laneOp.tag  = issueBeat.tag;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			running <= 1'b0;
			rrPtr   <= '0;
		end else begin
			running <= 1'b1;
			if (accept && decoded.isMulDiv) begin
				rrPtr <= IDXW'((int'(laneSel) + 1) % `MD_LANES); // Next search past this lane
			end
		end
	end

	// Busy comes from the lanes, start from this block
	startIdleLane: assert property (@(posedge clk) disable iff (!arstN)
		(laneStart & laneBusy) == '0)
		else $error("start pulsed to a busy lane");

endmodule

/* logic/mainDecoder.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module mainDecoder import rvIsaPkg::*; (
	input  logic [`XLEN-1:0] instr,
	output ctrlBundleS       ctrl
);
	opcodeE     opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;

	assign opcode = opcodeE'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	always_comb begin
		// Every field gets a value on every path
		ctrl            = '0;
		ctrl.immSrc     = IMM_I;
		ctrl.aluSrcA    = 2'b01;
		ctrl.resultSrc  = RES_ALU;
		ctrl.writeType  = WT_WORD;
		ctrl.mulDivFunc = MD_MUL;
		case (opcode)
			OP_R: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp    = 2'b10;
				if (funct7 == 7'b0000001) begin // M extension
					ctrl.isMulDiv   = 1'b1;
					ctrl.mulDivFunc = mulDivFuncE'(funct3);
				end
			end
			OP_I: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcB  = 1'b1;
				ctrl.aluOp    = 2'b01;
			end
			OP_S: begin
				ctrl.immSrc   = IMM_S;
				ctrl.aluSrcB  = 1'b1;
				ctrl.memWrite = 1'b1;
				case (funct3) // Store width
					3'b000:  ctrl.writeType = WT_BYTE;
					3'b001:  ctrl.writeType = WT_HALF;
					3'b010:  ctrl.writeType = WT_WORD;
					default: ctrl.writeType = WT_OTHER;
				endcase
			end
			OP_L: begin
				ctrl.regWrite  = 1'b1;
				ctrl.aluSrcB   = 1'b1;
				ctrl.resultSrc = RES_MEM;
			end
			OP_B: begin
				ctrl.immSrc = IMM_BJ;
				ctrl.branch = 1'b1;
				ctrl.aluOp  = 2'b11;
			end
			OP_JAL, OP_JALR: begin
				ctrl.regWrite  = 1'b1;
				ctrl.immSrc    = IMM_BJ;
				ctrl.aluOp     = 2'b01;
				ctrl.resultSrc = RES_PC4; // Link value
				ctrl.jump      = 1'b1;
				if (opcode == OP_JALR) begin
					ctrl.immSrc   = IMM_I; // Target is rs1 plus I immediate
					ctrl.aluSrcB  = 1'b1;
					ctrl.pcJalSrc = 1'b1;
				end
			end
			OP_LUI, OP_AUIPC: begin
				ctrl.regWrite = 1'b1;
				ctrl.immSrc   = IMM_U;
				ctrl.aluSrcB  = 1'b1;
				ctrl.aluOp    = 2'b01;
				ctrl.aluSrcA  = (opcode == OP_LUI) ? 2'b00 : 2'b10;
			end
			default: begin
				// Unknown opcode, nothing may be written
				ctrl.illegal = 1'b1;
				ctrl.aluSrcA = 2'b00;
				ctrl.aluOp   = 2'b10;
			end
		endcase
	end

endmodule

/* logic/mulDivLane.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module mulDivLane import rvIsaPkg::*, rvStreamPkg::*; (
	input  logic     clk,
	input  logic     arstN,
	input  logic     start,
	input  mdOpS     op,
	input  logic     resultReady,
	output logic     busy,
	output logic     resultValid,
	output mdResultS result
);
	typedef enum logic [2:0] {IDLE, PREP, RUN, FIX, DONE} stateE;
	localparam int CNTW = $clog2(`XLEN);

	stateE              state;
	logic [CNTW-1:0]    stepCnt;
	mdOpS               opReg;
	logic [`XLEN-1:0]   hi;    // Product high half or partial remainder
	logic [`XLEN-1:0]   lo;    // Multiplier or dividend/quotient
	logic [`XLEN-1:0]   opnd;  // Multiplicand or divisor
	logic               negRes;
	logic               remNeg;
	logic               divZero;
	logic               isDiv;
	logic               aNeg;
	logic               bNeg;
	logic [`XLEN-1:0]   aMag;
	logic [`XLEN-1:0]   bMag;
	logic [`XLEN:0]     mulSum;
	logic [`XLEN:0]     divTrial;
	logic [2*`XLEN-1:0] prodFix;
	logic [`XLEN-1:0]   quoFix;
	logic [`XLEN-1:0]   remFix;
	logic [`XLEN-1:0]   resValue;

	assign isDiv = opReg.func inside {MD_DIV, MD_DIVU, MD_REM, MD_REMU};
	// MUL low word is the same for signed and unsigned
	assign aNeg  = opReg.a[`XLEN-1] && (opReg.func inside {MD_MULH, MD_MULHSU, MD_DIV, MD_REM});
	assign bNeg  = opReg.b[`XLEN-1] && (opReg.func inside {MD_MULH, MD_DIV, MD_REM});
	assign aMag  = aNeg ? -opReg.a : opReg.a;
	assign bMag  = bNeg ? -opReg.b : opReg.b;

	assign mulSum   = {1'b0, hi} + (lo[0] ? {1'b0, opnd} : '0);
	assign divTrial = {hi, lo[`XLEN-1]} - {1'b0, opnd}; // MSB set means no subtract

	// Most negative / -1 needs no special path, 2^31 negated is the dividend again
	always_comb begin
		prodFix = negRes ? -{hi, lo} : {hi, lo};
		quoFix  = negRes ? -lo : lo;
		remFix  = remNeg ? -hi : hi;
		case (opReg.func)
			MD_MUL:                       resValue = prodFix[`XLEN-1:0];
			MD_MULH, MD_MULHSU, MD_MULHU: resValue = prodFix[2*`XLEN-1:`XLEN];
			MD_DIV, MD_DIVU:              resValue = divZero ? '1 : quoFix;
			default:                      resValue = remFix;
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state   <= IDLE;
			stepCnt <= '0;
		end else begin
			case (state)
				IDLE: if (start) state <= PREP;
				PREP: begin
					state   <= RUN;
					stepCnt <= '0;
				end
				RUN: begin
					stepCnt <= stepCnt + 1'b1;
					if (stepCnt == CNTW'(`XLEN - 1)) state <= FIX;
				end
				FIX:     state <= DONE;
				DONE:    if (resultReady) state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			IDLE: if (start) opReg <= op;
			PREP: begin
				negRes  <= aNeg ^ bNeg;
				remNeg  <= aNeg;         // Remainder takes the dividend sign
				divZero <= isDiv && (opReg.b == '0);
				hi      <= '0;
				opnd    <= isDiv ? bMag : aMag;
				lo      <= isDiv ? aMag : bMag;
			end
			RUN: begin
				if (isDiv) begin
					hi <= divTrial[`XLEN] ? {hi[`XLEN-2:0], lo[`XLEN-1]} : divTrial[`XLEN-1:0];
					lo <= {lo[`XLEN-2:0], !divTrial[`XLEN]};
				end else begin
					{hi, lo} <= {mulSum, lo[`XLEN-1:1]};
				end
			end
			FIX: begin
				result.tag   <= opReg.tag;
				result.value <= resValue;
			end
			default: ;
		endcase
	end

	assign busy        = (state != IDLE);
	assign resultValid = (state == DONE);

	noStartWhenBusy: assert property (@(posedge clk) disable iff (!arstN) start |-> !busy)
		else $error("lane started while busy");

endmodule

/* logic/resultCollector.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module resultCollector import rvStreamPkg::*; (
	input  logic                 clk,
	input  logic                 arstN,
	input  logic [`MD_LANES-1:0] laneValid,
	input  mdResultS             laneResult [`MD_LANES],
	input  logic                 outReady,
	output logic [`MD_LANES-1:0] laneReady,
	output logic                 outValid,
	output mdResultS             outResult
);
	localparam int IDXW = (`MD_LANES > 1) ? $clog2(`MD_LANES) : 1;

	logic [IDXW-1:0]      lastGnt;
	logic [IDXW-1:0]      gntIdx;
	logic [`MD_LANES-1:0] grant;

	// Search starts one past the last granted lane
	always_comb begin
		int idx;
		outValid = 1'b0;
		gntIdx   = lastGnt;
		grant    = '0;
		for (int k = 1; k <= `MD_LANES; k++) begin
			idx = (int'(lastGnt) + k) % `MD_LANES;
			if (!outValid && laneValid[idx]) begin
				outValid   = 1'b1;
				gntIdx     = IDXW'(idx);
				grant[idx] = 1'b1;
			end
		end
	end

	assign laneReady = outReady ? grant : '0;
	assign outResult = laneResult[gntIdx];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			lastGnt <= IDXW'(`MD_LANES - 1); // Lane 0 wins first
		end else if (outValid && outReady) begin
			lastGnt <= gntIdx;
		end
	end

	grantOneHot: assert property (@(posedge clk) disable iff (!arstN) $onehot0(grant))
		else $error("collector grant not one-hot");

endmodule

/* logic/rvIsaPkg.sv */
`include "rv_config.svh"

package rvIsaPkg;

	// Base opcodes recognized by the main decoder
	typedef enum logic [6:0] {
		OP_R     = 7'b0110011,
		OP_I     = 7'b0010011,
		OP_S     = 7'b0100011,
		OP_L     = 7'b0000011,
		OP_B     = 7'b1100011,
		OP_JAL   = 7'b1101111,
		OP_JALR  = 7'b1100111,
		OP_LUI   = 7'b0110111,
		OP_AUIPC = 7'b0010111
	} opcodeE;

	// M extension functions, value equals funct3
	typedef enum logic [2:0] {
		MD_MUL    = 3'd0,
		MD_MULH   = 3'd1,
		MD_MULHSU = 3'd2,
		MD_MULHU  = 3'd3,
		MD_DIV    = 3'd4,
		MD_DIVU   = 3'd5,
		MD_REM    = 3'd6,
		MD_REMU   = 3'd7
	} mulDivFuncE;

	typedef enum logic [1:0] {IMM_I, IMM_S, IMM_BJ, IMM_U} immSrcE;
	typedef enum logic [1:0] {RES_ALU, RES_MEM, RES_PC4} resultSrcE;
	typedef enum logic [1:0] {WT_BYTE, WT_HALF, WT_WORD, WT_OTHER} writeTypeE;

	typedef struct packed {
		logic                 regWrite;
		immSrcE               immSrc;
		logic [1:0]           aluSrcA;   // 00 zero, 01 rs1, 10 PC
		logic                 aluSrcB;   // Immediate when set
		logic                 memWrite;
		resultSrcE            resultSrc;
		logic                 branch;
		logic                 jump;
		logic [1:0]           aluOp;
		logic                 pcJalSrc;  // JALR target from rs1
		writeTypeE            writeType;
		logic                 isMulDiv;
		mulDivFuncE           mulDivFunc;
		logic                 illegal;
		logic [`TAG_BITS-1:0] tag;
	} ctrlBundleS;

endpackage

/* logic/rvStreamPkg.sv */
`include "rv_config.svh"

package rvStreamPkg;
	import rvIsaPkg::*;

	// One instruction on the issue port
	typedef struct packed {
		logic [`XLEN-1:0]     instr;
		logic [`XLEN-1:0]     rs1Val;
		logic [`XLEN-1:0]     rs2Val;
		logic [`TAG_BITS-1:0] tag;
	} issueBeatS;

	// Work handed to a multiply/divide lane
	typedef struct packed {
		mulDivFuncE           func;
		logic [`XLEN-1:0]     a; // rs1
		logic [`XLEN-1:0]     b; // rs2
		logic [`TAG_BITS-1:0] tag;
	} mdOpS;

	typedef struct packed {
		logic [`TAG_BITS-1:0] tag;
		logic [`XLEN-1:0]     value;
	} mdResultS;

endpackage

/* logic/rv_config.svh */
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

`define XLEN       32 // Data word width
`define MD_LANES   2  // Multiply/divide lanes, works for 1 to 4
`define FIFO_DEPTH 4  // Default depth of the stream FIFOs

// Instruction tag carried along with every bundle and result
`define TAG_BITS   4

`endif

/* logic/streamFifo.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module streamFifo #(
	parameter type T     = logic,
	parameter int  DEPTH = `FIFO_DEPTH
) (
	input  logic clk,
	input  logic arstN,
	input  logic inValid,
	input  T     inData,
	input  logic outReady,
	output logic inReady,
	output logic outValid,
	output T     outData
);
	localparam int PTRW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNTW = $clog2(DEPTH + 1);

	T                mem [DEPTH];
	logic [PTRW-1:0] rdPtr;
	logic [PTRW-1:0] wrPtr;
	logic [CNTW-1:0] count;
	logic            push;
	logic            pop;

	assign inReady  = (count != CNTW'(DEPTH));
	assign outValid = (count != '0);
	assign outData  = mem[rdPtr];
	assign push     = inValid && inReady;
	assign pop      = outValid && outReady;

	always_ff @(posedge clk) begin
		if (push) mem[wrPtr] <= inData;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
		end else begin
			if (push) wrPtr <= (wrPtr == PTRW'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			if (pop)  rdPtr <= (rdPtr == PTRW'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			count <= count + CNTW'(push) - CNTW'(pop); // Both at once leaves it
		end
	end

	noOverflow: assert property (@(posedge clk) disable iff (!arstN)
		count <= CNTW'(DEPTH))
		else $error("FIFO count above its depth");

	noUnderflow: assert property (@(posedge clk) disable iff (!arstN)
		count == '0 |=> count <= CNTW'(1))
		else $error("FIFO count wrapped below zero");

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f sim.f \
	--top-module decodeMulDivTb -o simv > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simv > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "CHECKS FAILED" "$SIM_LOG"; then
	exit 1
fi
exit 0

/* sim.f */
+incdir+logic
+incdir+bench
logic/rvIsaPkg.sv
logic/rvStreamPkg.sv
logic/mainDecoder.sv
logic/streamFifo.sv
logic/mulDivLane.sv
logic/resultCollector.sv
logic/issueDispatch.sv
logic/decodeMulDivUnit.sv
bench/decodeMulDivTb.sv
